//--- logic/link_fifo_pkg.sv
package link_fifo_pkg;

  ////////////////////
  // widths and counts
  localparam int DATA_W      = 32;
  localparam int ADDR_W      = 12;
  localparam int MASK_W      = DATA_W / 8;
  localparam int COORD_W     = 4;
  localparam int OUT_SCALE   = 2;
  localparam int CHAN_SCALE  = 2;
  localparam int NUM_LINKS   = OUT_SCALE * CHAN_SCALE;
  localparam int OUT_W       = DATA_W * OUT_SCALE;
  localparam int EP_FIFO_ELS = 4;

  // endpoint queue pointer and occupancy widths
  localparam int EP_PTR_W = $clog2(EP_FIFO_ELS);
  localparam int EP_CNT_W = $clog2(EP_FIFO_ELS + 1);

  // arbiter group index width
  localparam int GRP_W = (CHAN_SCALE > 1) ? $clog2(CHAN_SCALE) : 1;

  ////////////////////
  // packet opcodes
  localparam logic [1:0] OP_READ  = 2'b00;
  localparam logic [1:0] OP_WRITE = 2'b01;

  // payload words
  typedef logic [DATA_W-1:0] lane_word_t;
  typedef logic [OUT_W-1:0]  out_word_t;

  typedef struct packed {
    logic [COORD_W-1:0] x;
    logic [COORD_W-1:0] y;
  } coord_t;

  // mesh packet, mask travels along but is not applied
  typedef struct packed {
    logic [1:0]        op;
    logic [ADDR_W-1:0] addr;
    logic [MASK_W-1:0] mask;
    lane_word_t        data;
    coord_t            dst;
    coord_t            src;
  } link_packet_t;

  typedef struct packed {
    logic         v;
    link_packet_t pkt;
  } link_in_t;

  typedef struct packed {
    logic ready;
  } link_out_t;

endpackage

//--- logic/relay_fifo.sv
module relay_fifo #(
  parameter type payload_t = link_fifo_pkg::lane_word_t
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     v_i,
  input  payload_t data_i,
  output logic     ready_o,
  output logic     v_o,
  output payload_t data_o,
  input  logic     ready_i
);

  // head drives the output, skid catches a word while head is blocked
  payload_t head_q;
  payload_t skid_q;
  logic     head_v_q;
  logic     skid_v_q;

  logic push;
  logic pop;
  logic load_head_in;
  logic load_skid;

  // skid only fills when head is already valid
  assign ready_o = ~skid_v_q;
  assign v_o     = head_v_q;
  assign data_o  = head_q;

  assign push = v_i & ready_o;
  assign pop  = head_v_q & ready_i;

  assign load_head_in = push & (~head_v_q | pop);
  assign load_skid    = push & head_v_q & ~pop;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      head_v_q <= 1'b0;
      skid_v_q <= 1'b0;
    end else begin
      head_v_q <= (head_v_q & ~pop) | push | (pop & skid_v_q);
      skid_v_q <= (skid_v_q & ~pop) | load_skid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop && skid_v_q) begin
      head_q <= skid_q;
    end else if (load_head_in) begin
      head_q <= data_i;
    end
    if (load_skid) begin
      skid_q <= data_i;
    end
  end

endmodule

//--- logic/link_endpoint.sv
module link_endpoint (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  link_fifo_pkg::link_in_t   link_i,
  input  link_fifo_pkg::coord_t     my_coord_i,
  output link_fifo_pkg::link_out_t  link_o,
  output logic                      v_o,
  output link_fifo_pkg::lane_word_t data_o,
  input  logic                      ready_i,
  output logic                      drop_o
);

  logic [link_fifo_pkg::EP_PTR_W-1:0] wr_q;
  logic [link_fifo_pkg::EP_PTR_W-1:0] rd_q;
  logic [link_fifo_pkg::EP_CNT_W-1:0] cnt_q;
  link_fifo_pkg::lane_word_t          mem_q [link_fifo_pkg::EP_FIFO_ELS];
  logic                               drop_q;

  logic full;
  logic accept;
  logic hit;
  logic push;
  logic pop;

  // circular pointer step
  function automatic logic [link_fifo_pkg::EP_PTR_W-1:0] ptr_next(
    input logic [link_fifo_pkg::EP_PTR_W-1:0] p
  );
    if (p == link_fifo_pkg::EP_PTR_W'(link_fifo_pkg::EP_FIFO_ELS - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  ////////////////////
  // link side filter
  assign full   = cnt_q == link_fifo_pkg::EP_CNT_W'(link_fifo_pkg::EP_FIFO_ELS);
  assign accept = link_i.v & ~full;
  assign hit    = (link_i.pkt.op == link_fifo_pkg::OP_WRITE) &&
                  (link_i.pkt.dst == my_coord_i);
  assign push   = accept & hit;

  assign link_o.ready = ~full;
  assign drop_o       = drop_q;

  ////////////////////
  // lane side
  assign v_o    = cnt_q != '0;
  assign data_o = mem_q[rd_q];
  assign pop    = v_o & ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_q   <= '0;
      rd_q   <= '0;
      cnt_q  <= '0;
      drop_q <= 1'b0;
    end else begin
      // bad packets are taken off the link but never queued
      drop_q <= accept & ~hit;
      if (push) begin
        wr_q <= ptr_next(wr_q);
      end
      if (pop) begin
        rd_q <= ptr_next(rd_q);
      end
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_q] <= link_i.pkt.data;
    end
  end

endmodule

//--- logic/width_merger.sv
module width_merger (
  input  logic                                                  clk_i,
  input  logic                                                  rst_i,
  input  logic [link_fifo_pkg::OUT_SCALE-1:0]                   lane_v_i,
  input  link_fifo_pkg::lane_word_t [link_fifo_pkg::OUT_SCALE-1:0] lane_data_i,
  output logic [link_fifo_pkg::OUT_SCALE-1:0]                   lane_ready_o,
  output logic                                                  v_o,
  output link_fifo_pkg::out_word_t                              data_o,
  input  logic                                                  ready_i
);

  logic                     all_v;
  logic                     join_ready;
  link_fifo_pkg::out_word_t joined;

  // a group only moves once every lane holds a word
  assign all_v = &lane_v_i;

  // lane 0 lands in the low bits
  always_comb begin
    joined = '0;
    for (int j = 0; j < link_fifo_pkg::OUT_SCALE; j++) begin
      joined[j*link_fifo_pkg::DATA_W +: link_fifo_pkg::DATA_W] = lane_data_i[j];
    end
  end

  // all lanes of the group pop on the same edge
  assign lane_ready_o = {link_fifo_pkg::OUT_SCALE{all_v & join_ready}};

  // buffer the joined word so arbiter stalls stay off the lane path
  relay_fifo #(
    .payload_t (link_fifo_pkg::out_word_t)
  ) u_join_relay (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .v_i     (all_v),
    .data_i  (joined),
    .ready_o (join_ready),
    .v_o     (v_o),
    .data_o  (data_o),
    .ready_i (ready_i)
  );

endmodule

//--- logic/rr_arbiter.sv
module rr_arbiter (
  input  logic                                                   clk_i,
  input  logic                                                   rst_i,
  input  logic [link_fifo_pkg::CHAN_SCALE-1:0]                   v_i,
  input  link_fifo_pkg::out_word_t [link_fifo_pkg::CHAN_SCALE-1:0] data_i,
  output logic [link_fifo_pkg::CHAN_SCALE-1:0]                   ready_o,
  output logic                                                   v_o,
  output link_fifo_pkg::out_word_t                               data_o,
  input  logic                                                   ready_i
);

  logic [link_fifo_pkg::GRP_W-1:0] last_q;
  logic [link_fifo_pkg::GRP_W-1:0] gnt_idx;
  logic                            any_v;
  logic                            out_ready;
  logic                            xfer;

  ////////////////////
  // grant search
  // scan starts one past the previous winner
  always_comb begin
    int idx;
    gnt_idx = last_q;
    any_v   = 1'b0;
    for (int k = 1; k <= link_fifo_pkg::CHAN_SCALE; k++) begin
      idx = (int'(last_q) + k) % link_fifo_pkg::CHAN_SCALE;
      if (!any_v && v_i[idx]) begin
        gnt_idx = link_fifo_pkg::GRP_W'(idx);
        any_v   = 1'b1;
      end
    end
  end

  assign xfer = any_v & out_ready;

  always_comb begin
    ready_o = '0;
    for (int k = 0; k < link_fifo_pkg::CHAN_SCALE; k++) begin
      ready_o[k] = xfer && (gnt_idx == link_fifo_pkg::GRP_W'(k));
    end
  end

  // priority pointer, last group at reset so group 0 wins first
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      last_q <= link_fifo_pkg::GRP_W'(link_fifo_pkg::CHAN_SCALE - 1);
    end else if (xfer) begin
      last_q <= gnt_idx;
    end
  end

  ////////////////////
  // output stage
  relay_fifo #(
    .payload_t (link_fifo_pkg::out_word_t)
  ) u_out_relay (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .v_i     (any_v),
    .data_i  (data_i[gnt_idx]),
    .ready_o (out_ready),
    .v_o     (v_o),
    .data_o  (data_o),
    .ready_i (ready_i)
  );

endmodule

//--- logic/link_to_fifo.sv
module link_to_fifo (
  input  logic                                                     clk_i,
  input  logic                                                     rst_i,
  input  link_fifo_pkg::coord_t   [link_fifo_pkg::NUM_LINKS-1:0]   my_coord_i,
  input  link_fifo_pkg::link_in_t [link_fifo_pkg::NUM_LINKS-1:0]   link_i,
  output link_fifo_pkg::link_out_t [link_fifo_pkg::NUM_LINKS-1:0]  link_o,
  output logic [link_fifo_pkg::NUM_LINKS-1:0]                      drop_o,
  output logic                                                     v_o,
  output link_fifo_pkg::out_word_t                                 data_o,
  input  logic                                                     ready_i
);

  // endpoint to lane relay
  logic [link_fifo_pkg::NUM_LINKS-1:0]                      ep_v;
  link_fifo_pkg::lane_word_t [link_fifo_pkg::NUM_LINKS-1:0] ep_data;
  logic [link_fifo_pkg::NUM_LINKS-1:0]                      ep_ready;

  // lane relay to merger
  logic [link_fifo_pkg::NUM_LINKS-1:0]                      lane_v;
  link_fifo_pkg::lane_word_t [link_fifo_pkg::NUM_LINKS-1:0] lane_data;
  logic [link_fifo_pkg::NUM_LINKS-1:0]                      lane_ready;

  // merger to arbiter
  logic [link_fifo_pkg::CHAN_SCALE-1:0]                     mrg_v;
  link_fifo_pkg::out_word_t [link_fifo_pkg::CHAN_SCALE-1:0] mrg_data;
  logic [link_fifo_pkg::CHAN_SCALE-1:0]                     mrg_ready;

  ////////////////////
  // input side
  for (genvar i = 0; i < link_fifo_pkg::NUM_LINKS; i++) begin : g_link
    link_endpoint u_endpoint (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .link_i     (link_i[i]),
      .my_coord_i (my_coord_i[i]),
      .link_o     (link_o[i]),
      .v_o        (ep_v[i]),
      .data_o     (ep_data[i]),
      .ready_i    (ep_ready[i]),
      .drop_o     (drop_o[i])
    );

    relay_fifo #(
      .payload_t (link_fifo_pkg::lane_word_t)
    ) u_lane_relay (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .v_i     (ep_v[i]),
      .data_i  (ep_data[i]),
      .ready_o (ep_ready[i]),
      .v_o     (lane_v[i]),
      .data_o  (lane_data[i]),
      .ready_i (lane_ready[i])
    );
  end

  ////////////////////
  // processing part
  // neighbouring lanes form one group
  for (genvar g = 0; g < link_fifo_pkg::CHAN_SCALE; g++) begin : g_group
    width_merger u_merger (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .lane_v_i     (lane_v[g*link_fifo_pkg::OUT_SCALE +: link_fifo_pkg::OUT_SCALE]),
      .lane_data_i  (lane_data[g*link_fifo_pkg::OUT_SCALE +: link_fifo_pkg::OUT_SCALE]),
      .lane_ready_o (lane_ready[g*link_fifo_pkg::OUT_SCALE +: link_fifo_pkg::OUT_SCALE]),
      .v_o          (mrg_v[g]),
      .data_o       (mrg_data[g]),
      .ready_i      (mrg_ready[g])
    );
  end

  ////////////////////
  // output side
  rr_arbiter u_arbiter (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .v_i     (mrg_v),
    .data_i  (mrg_data),
    .ready_o (mrg_ready),
    .v_o     (v_o),
    .data_o  (data_o),
    .ready_i (ready_i)
  );

endmodule

//--- verif/link_to_fifo_checker.sv
module link_to_fifo_checker (
  input logic                                                    clk_i,
  input logic                                                    rst_i,
  input link_fifo_pkg::coord_t    [link_fifo_pkg::NUM_LINKS-1:0] my_coord_i,
  input link_fifo_pkg::link_in_t  [link_fifo_pkg::NUM_LINKS-1:0] link_i,
  input link_fifo_pkg::link_out_t [link_fifo_pkg::NUM_LINKS-1:0] link_o,
  input logic [link_fifo_pkg::NUM_LINKS-1:0]                     drop_o,
  input logic                                                    v_o,
  input link_fifo_pkg::out_word_t                                data_o,
  input logic                                                    ready_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // count of failing assertions
  int unsigned fail_cnt = 0;

  logic [link_fifo_pkg::NUM_LINKS-1:0] link_ready;
  logic [link_fifo_pkg::NUM_LINKS-1:0] bad_pkt;

  // a packet is bad unless it is a write to this link's tile
  always_comb begin
    for (int i = 0; i < link_fifo_pkg::NUM_LINKS; i++) begin
      link_ready[i] = link_o[i].ready;
      bad_pkt[i]    = (link_i[i].pkt.op != link_fifo_pkg::OP_WRITE) ||
                      (link_i[i].pkt.dst != my_coord_i[i]);
    end
  end

  ////////////////////
  // reset and output
  reset_idle_a: assert property (
    @(posedge clk_i) $fell(rst_i) |-> (!v_o && (drop_o == '0) && (&link_ready))
  ) else begin
    fail_cnt++;
    $error("outputs not idle in the first cycle after reset");
  end

  output_hold_a: assert property (
    @(posedge clk_i) disable iff (rst_i) (v_o && !ready_i) |=> (v_o && $stable(data_o))
  ) else begin
    fail_cnt++;
    $error("v_o or data_o changed while the sink held ready_i low");
  end

  ////////////////////
  // per link filter
  for (genvar i = 0; i < link_fifo_pkg::NUM_LINKS; i++) begin : g_link
    drop_after_bad_a: assert property (
      @(posedge clk_i) disable iff (rst_i)
      (link_i[i].v && link_ready[i] && bad_pkt[i]) |=> drop_o[i]
    ) else begin
      fail_cnt++;
      $error("no drop_o after a bad packet on link %0d", i);
    end

    // ready link with no bad packet offered
    no_spurious_drop_a: assert property (
      @(posedge clk_i) disable iff (rst_i)
      (link_ready[i] && !(link_i[i].v && bad_pkt[i])) |=> !drop_o[i]
    ) else begin
      fail_cnt++;
      $error("drop_o on link %0d without a bad packet", i);
    end

    // offered packet on a full link must not be taken
    stalled_link_a: assert property (
      @(posedge clk_i) disable iff (rst_i)
      (link_i[i].v && !link_ready[i]) |=> !drop_o[i]
    ) else begin
      fail_cnt++;
      $error("link %0d took a packet while its ready was low", i);
    end
  end

endmodule

//--- verif/link_to_fifo_tb.sv
module link_to_fifo_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int LINKS      = link_fifo_pkg::NUM_LINKS;
  localparam int SCALE      = link_fifo_pkg::OUT_SCALE;
  localparam int GROUPS     = link_fifo_pkg::CHAN_SCALE;
  localparam int DW         = link_fifo_pkg::DATA_W;
  localparam int TAG_W      = 4;
  localparam int CLK_NS     = 4;
  localparam int RESET_CYC  = 8;
  localparam int RANDOM_CYC = 400;
  localparam int FILL_CYC   = 100;
  localparam int HOLD_CYC   = 20;
  localparam int DRAIN_CYC  = 300;
  localparam int IDLE_CYC   = 10;
  localparam int FAIR_DEPTH = 1;
  localparam int RUN_CYC    = RESET_CYC + RANDOM_CYC + FILL_CYC + HOLD_CYC +
                              2 * (DRAIN_CYC + IDLE_CYC);

  logic                                     clk_i = 1'b0;
  logic                                     rst_i;
  link_fifo_pkg::coord_t    [LINKS-1:0]     my_coord_i;
  link_fifo_pkg::link_in_t  [LINKS-1:0]     link_i;
  link_fifo_pkg::link_out_t [LINKS-1:0]     link_o;
  logic [LINKS-1:0]                         drop_o;
  logic                                     v_o;
  link_fifo_pkg::out_word_t                 data_o;
  logic                                     ready_i;

  logic [31:0]               seed;
  logic [LINKS-1:0]          is_good;
  link_fifo_pkg::lane_word_t ref_q [LINKS][$];
  int                        err_data;
  int                        err_other;
  bit                        fair_mode;
  int                        last_grp;
  int                        out_idx;

  always #(CLK_NS / 2) clk_i = ~clk_i;

  link_to_fifo UUT (.*);

  bind link_to_fifo link_to_fifo_checker u_checker (
    .clk_i(clk_i), .rst_i(rst_i), .my_coord_i(my_coord_i), .link_i(link_i), .link_o(link_o),
    .drop_o(drop_o), .v_o(v_o), .data_o(data_o), .ready_i(ready_i)
  );

  // LCG, upper half of the state is the useful part
  function automatic int unsigned pick(input int unsigned n);
    seed = seed * 32'd1103515245 + 32'd12345;
    return (seed >> 16) % n;
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = pick(32'h10000);
    lo = pick(32'h10000);
    return {hi[15:0], lo[15:0]};
  endfunction

  // good words carry the link number in the top bits, bad ones an unused tag
  function automatic link_fifo_pkg::link_packet_t make_packet(input int link, input bit good);
    link_fifo_pkg::link_packet_t p;
    logic [31:0] r;
    r      = rand_word();
    p.op   = link_fifo_pkg::OP_WRITE;
    p.addr = r[link_fifo_pkg::ADDR_W-1:0];
    p.mask = r[16 +: link_fifo_pkg::MASK_W];
    p.src  = r[31:24];
    p.dst  = my_coord_i[link];
    r      = rand_word();
    if (good) begin
      p.data = {TAG_W'(link), r[DW-TAG_W-1:0]};
    end else begin
      p.data = {{TAG_W{1'b1}}, r[DW-TAG_W-1:0]};
      if (pick(2) == 0) begin
        p.op = link_fifo_pkg::OP_READ;
      end else begin
        p.dst.x = p.dst.x ^ link_fifo_pkg::COORD_W'(8);
      end
    end
    return p;
  endfunction

  task automatic offer(input int link, input bit good);
    link_i[link].v   = 1'b1;
    link_i[link].pkt = make_packet(link, good);
    is_good[link]    = good;
  endtask

  // shallowest lane decides how many whole words a group still owes
  function automatic int group_depth(input int g);
    int d;
    d = ref_q[g*SCALE].size();
    for (int j = 1; j < SCALE; j++) begin
      if (ref_q[g*SCALE+j].size() < d) begin
        d = ref_q[g*SCALE+j].size();
      end
    end
    return d;
  endfunction

  function automatic bit all_empty();
    for (int i = 0; i < LINKS; i++) begin
      if (ref_q[i].size() != 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  function automatic bit any_link_ready();
    for (int i = 0; i < LINKS; i++) begin
      if (link_o[i].ready) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic check_output();
    int tag;
    int grp;
    int shallow;
    link_fifo_pkg::out_word_t expected;
    tag = int'(data_o[DW-1 -: TAG_W]);
    grp = tag / SCALE;
    if (tag >= LINKS || tag % SCALE != 0) begin
      err_other++;
      $display("output word at %0t carries lane tag %0d, which names no group", $time, tag);
    end else if (group_depth(grp) == 0) begin
      err_other++;
      $display("output word at %0t came from group %0d with nothing expected", $time, grp);
    end else begin
      shallow = group_depth(0);
      for (int g = 1; g < GROUPS; g++) begin
        if (group_depth(g) < shallow) begin
          shallow = group_depth(g);
        end
      end
      // the first two words were granted during the stall
      if (fair_mode && out_idx >= 2 && shallow >= FAIR_DEPTH) begin
        assert (grp != last_grp) else begin
          err_other++;
          $display("group %0d won twice in a row at %0t with every group waiting", grp, $time);
        end
      end
      expected = '0;
      for (int j = 0; j < SCALE; j++) begin
        expected[j*DW +: DW] = ref_q[grp*SCALE+j].pop_front();
      end
      assert (data_o == expected) else begin
        err_data++;
        $display("error at %0t: data_o expected %h actual %h", $time, expected, data_o);
      end
      last_grp = grp;
      out_idx++;
    end
  endtask

  // called a little after the falling edge, when inputs and outputs are settled
  task automatic observe();
    for (int i = 0; i < LINKS; i++) begin
      if (link_i[i].v && link_o[i].ready && is_good[i]) begin
        ref_q[i].push_back(link_i[i].pkt.data);
      end
    end
    if (v_o && ready_i) begin
      check_output();
    end
  endtask

  ////////////////////
  // test phases
  task automatic random_traffic();
    repeat (RANDOM_CYC) begin
      @(negedge clk_i);
      ready_i = (pick(4) != 0);
      link_i  = '0;
      is_good = '0;
      for (int i = 0; i < LINKS; i++) begin
        if (pick(2) == 0) begin
          offer(i, pick(8) != 0);
        end
      end
      #1;
      observe();
    end
  endtask

  // sink stalled, links pushed until all of them are full
  task automatic fill_and_stall();
    int n;
    n = 0;
    while (any_link_ready() && n < FILL_CYC) begin
      @(negedge clk_i);
      ready_i = 1'b0;
      for (int i = 0; i < LINKS; i++) begin
        offer(i, 1'b1);
      end
      #1;
      observe();
      n++;
    end
    if (any_link_ready()) begin
      err_other++;
      $display("link ready did not fall while the sink held ready_i low");
    end
    repeat (HOLD_CYC) begin
      @(negedge clk_i);
      for (int i = 0; i < LINKS; i++) begin
        offer(i, pick(2) == 0);
      end
      #1;
      observe();
    end
  endtask

  task automatic drain(input bit fair);
    int n;
    int top;
    n         = 0;
    out_idx   = 0;
    fair_mode = fair;
    while (!all_empty() && n < DRAIN_CYC) begin
      @(negedge clk_i);
      ready_i = 1'b1;
      link_i  = '0;
      is_good = '0;
      // top up short lanes so every group can still merge
      for (int g = 0; g < GROUPS; g++) begin
        top = 0;
        for (int j = 0; j < SCALE; j++) begin
          if (ref_q[g*SCALE+j].size() > top) begin
            top = ref_q[g*SCALE+j].size();
          end
        end
        for (int j = 0; j < SCALE; j++) begin
          if (ref_q[g*SCALE+j].size() < top) begin
            offer(g * SCALE + j, 1'b1);
          end
        end
      end
      #1;
      observe();
      n++;
    end
    fair_mode = 1'b0;
    if (!all_empty()) begin
      err_other++;
      $display("drain timed out with words still missing from data_o");
    end
    repeat (IDLE_CYC) begin
      @(negedge clk_i);
      link_i  = '0;
      is_good = '0;
      #1;
      observe();
    end
  endtask

  initial begin
    seed      = 32'd82;
    rst_i     = 1'b1;
    ready_i   = 1'b0;
    link_i    = '0;
    is_good   = '0;
    fair_mode = 1'b0;
    last_grp  = 0;
    out_idx   = 0;
    err_data  = 0;
    err_other = 0;
    for (int i = 0; i < LINKS; i++) begin
      my_coord_i[i].x = link_fifo_pkg::COORD_W'(i + 1);
      my_coord_i[i].y = link_fifo_pkg::COORD_W'(2);
    end
    repeat (RESET_CYC) @(negedge clk_i);
    rst_i = 1'b0;

    random_traffic();
    drain(1'b0);
    fill_and_stall();
    drain(1'b1);

    $display("summary: %0d data mismatches, %0d other failures, %0d checker failures",
             err_data, err_other, UUT.u_checker.fail_cnt);
    if (err_data == 0 && err_other == 0 && UUT.u_checker.fail_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // watchdog, twice the longest run the phases allow
  initial begin
    #(RUN_CYC * CLK_NS * 2);
    $display("watchdog expired before the test sequence finished");
    $display("=== FAIL ===");
    $finish;
  end

endmodule

//--- filelist.f
logic/link_fifo_pkg.sv
logic/relay_fifo.sv
logic/link_endpoint.sv
logic/width_merger.sv
logic/rr_arbiter.sv
logic/link_to_fifo.sv
verif/link_to_fifo_checker.sv
verif/link_to_fifo_tb.sv

//--- Makefile
# Verilator build and run of the link to FIFO testbench

VERILATOR ?= verilator
TOP       ?= link_to_fifo_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  := === PASS ===

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS RUN_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@grep -q -F "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
